// ==== Bender.yml ====
package:
  name: perf_mon

sources:
  - files:
      - hw/PerfMonPkg.sv
      - hw/PrefixAnd.sv
      - hw/EventCounter.sv
      - hw/WindowTimer.sv
      - hw/SampleFsm.sv
      - hw/AxiLiteRegs.sv
      - hw/PerfMonTop.sv
  - target: test
    files:
      - test/PerfMonTb.sv

// ==== build.f ====
hw/PerfMonPkg.sv
hw/PrefixAnd.sv
hw/EventCounter.sv
hw/WindowTimer.sv
hw/SampleFsm.sv
hw/AxiLiteRegs.sv
hw/PerfMonTop.sv
test/PerfMonTb.sv

// ==== hw/AxiLiteRegs.sv ====
`timescale 1ns/100ps

module AxiLiteRegs (
	input  logic clk,
	input  logic rstN,
	input  logic [PerfMonPkg::addrWidth-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [PerfMonPkg::dataWidth-1:0] wData,
	input  logic [PerfMonPkg::dataWidth/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [PerfMonPkg::addrWidth-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [PerfMonPkg::dataWidth-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	input  logic busy, // Window running
	input  logic done,
	input  logic [PerfMonPkg::numCounters*PerfMonPkg::dataWidth-1:0] counts,
	input  logic [PerfMonPkg::numCounters-1:0] saturated,
	output logic startReq,
	output logic clearReq,
	output logic ackDone,
	output logic [PerfMonPkg::timerWidth-1:0] windowLen,
	output logic [PerfMonPkg::numCounters-1:0] preloadEn, // One-hot
	output logic [PerfMonPkg::dataWidth-1:0] preloadData
);
	import PerfMonPkg::*;

	logic wrAccept;
	logic rdAccept;
	logic fullWord; // All strobes set
	logic wrCounter;
	logic rdCounter;
	logic [counterIdxWidth-1:0] wrIdx;
	logic [counterIdxWidth-1:0] rdIdx;
	ctrlWordU cmdWord; // Write view
	ctrlWordU statusWord; // Read view
	logic [dataWidth-1:0] rdMux;
	logic rdHit;

	// Word-aligned and inside the counter window
	function automatic logic isCounter(input logic [addrWidth-1:0] addr);
		return addr >= counterBase && addr < counterBase + 4 * numCounters
			&& addr[1:0] == 2'b00;
	endfunction

	function automatic logic [counterIdxWidth-1:0] counterIdx(input logic [addrWidth-1:0] addr);
		logic [addrWidth-1:0] offset;
		offset = addr - counterBase;
		return offset[counterIdxWidth+1:2];
	endfunction

	assign wrAccept = awValid && wValid && !bValid; // One write in flight
	assign awReady = wrAccept;
	assign wReady = wrAccept;
	assign fullWord = &wStrb;
	assign wrCounter = isCounter(awAddr);
	assign wrIdx = counterIdx(awAddr);
	assign cmdWord = wData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			bValid <= 1'b0;
			startReq <= 1'b0;
			clearReq <= 1'b0;
			ackDone <= 1'b0;
			preloadEn <= '0;
			windowLen <= '0;
		end else begin
			startReq <= 1'b0; // Pulses by default
			clearReq <= 1'b0;
			ackDone <= 1'b0;
			preloadEn <= '0;
			if (bValid && bReady) bValid <= 1'b0;
			if (wrAccept) begin
				bValid <= 1'b1;
				if (fullWord && awAddr == ctrlAddr) begin
					startReq <= cmdWord.wr.start;
					clearReq <= cmdWord.wr.clear && !busy; // Idle or done only
					ackDone <= cmdWord.wr.ackDone;
				end else if (fullWord && awAddr == windowAddr) begin
					windowLen <= wData[timerWidth-1:0];
				end else if (fullWord && wrCounter && !busy) begin
					preloadEn <= numCounters'(1) << wrIdx;
				end
			end
		end
	end

	// Response and preload payload
	always_ff @(posedge clk) begin
		if (wrAccept) begin
			preloadData <= wData;
			bResp <= (fullWord && (awAddr == ctrlAddr || awAddr == windowAddr || wrCounter))
				? axiRespOkay : axiRespSlvErr; // Partial strobes refused
		end
	end

	assign rdAccept = arValid && arReady;
	assign rdCounter = isCounter(arAddr);
	assign rdIdx = counterIdx(arAddr);

	always_comb begin
		statusWord = '0;
		statusWord.st.busy = busy;
		statusWord.st.done = done;
		statusWord.st.saturated = saturated;
		rdHit = 1'b1;
		rdMux = '0; // Unmapped reads return zero
		if (arAddr == ctrlAddr) begin
			rdMux = statusWord;
		end else if (arAddr == windowAddr) begin
			rdMux = dataWidth'(windowLen);
		end else if (rdCounter) begin
			rdMux = counts[rdIdx*dataWidth +: dataWidth];
		end else begin
			rdHit = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rValid <= 1'b0;
			arReady <= 1'b0;
		end else begin
			if (rdAccept) rValid <= 1'b1;
			else if (rReady) rValid <= 1'b0;
			arReady <= !(rdAccept || (rValid && !rReady)); // High while no read pending
		end
	end

	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rData <= rdMux;
			rResp <= rdHit ? axiRespOkay : axiRespSlvErr;
		end
	end

	bHold: assert property (@(posedge clk) disable iff (!rstN)
		bValid && !bReady |=> bValid);
	rHold: assert property (@(posedge clk) disable iff (!rstN)
		rValid && !rReady |=> rValid && $stable(rData));

endmodule

// ==== hw/EventCounter.sv ====
`timescale 1ns/100ps

module EventCounter (
	input  logic clk,
	input  logic rstN,
	input  logic eventLine, // Event input bit
	input  logic countEn,
	input  logic clear,
	input  logic preloadEn,
	input  logic [PerfMonPkg::dataWidth-1:0] preloadData,
	output logic [PerfMonPkg::dataWidth-1:0] count,
	output logic saturated
);
	import PerfMonPkg::*;

	logic [dataWidth-1:0] onesRun; // Bits 0..i all one
	logic [dataWidth-1:0] toggle; // Plus-one flip mask
	logic allOnes;

	PrefixAnd #(.width(dataWidth), .speed(2)) incPrefix (.PI(count), .PO(onesRun));

	assign toggle = {onesRun[dataWidth-2:0], 1'b1}; // Bit i flips when lower bits are ones
	assign allOnes = onesRun[dataWidth-1];

	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			count <= '0;
			saturated <= 1'b0;
		end else if (preloadEn) begin
			count <= preloadData;
			saturated <= 1'b0;
		end else if (countEn && eventLine) begin
			if (!allOnes) count <= count ^ toggle; // Held at all ones
			saturated <= saturated | allOnes; // Sticky
		end
	end

	// Clear and preload are held off by the register block during a window
	monotonic: assert property (@(posedge clk) disable iff (!rstN)
		countEn |=> count >= $past(count));

endmodule

// ==== hw/PerfMonPkg.sv ====
package PerfMonPkg;

	localparam int dataWidth = 32; // AXI word and counter width
	localparam int addrWidth = 8;
	localparam int timerWidth = 16; // Window length and timer
	localparam int numCounters = 4;
	localparam int counterIdxWidth = $clog2(numCounters);

	// Register map
	localparam logic [addrWidth-1:0] ctrlAddr = 8'h00; // Commands on write, status on read
	localparam logic [addrWidth-1:0] windowAddr = 8'h04;
	localparam logic [addrWidth-1:0] counterBase = 8'h10; // Counter k at base + 4k

	localparam logic [1:0] axiRespOkay = 2'b00;
	localparam logic [1:0] axiRespSlvErr = 2'b10;

	typedef enum logic [1:0] {
		stateIdle,
		stateCounting,
		stateDone
	} fsmStateT;

	// Write view of the control word
	typedef struct packed {
		logic [dataWidth-4:0] reserved;
		logic ackDone; // Leave done, back to idle
		logic clear; // Zero all counters
		logic start; // Bit 0
	} ctrlWriteT;

	// Read view of the same address
	typedef struct packed {
		logic [dataWidth-numCounters-3:0] reserved;
		logic [numCounters-1:0] saturated; // One per counter
		logic done;
		logic busy; // Bit 0
	} ctrlStatusT;

	typedef union packed {
		ctrlWriteT wr;
		ctrlStatusT st;
	} ctrlWordU;

endpackage

// ==== hw/PerfMonTop.sv ====
`timescale 1ns/100ps

module PerfMonTop (
	input  logic clk,
	input  logic rstN,
	input  logic [PerfMonPkg::addrWidth-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [PerfMonPkg::dataWidth-1:0] wData,
	input  logic [PerfMonPkg::dataWidth/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [PerfMonPkg::addrWidth-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [PerfMonPkg::dataWidth-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	input  logic [PerfMonPkg::numCounters-1:0] events // Sampled each edge
);
	import PerfMonPkg::*;

	logic startReq;
	logic clearReq;
	logic ackDone;
	logic [timerWidth-1:0] windowLen;
	logic [numCounters-1:0] preloadEn;
	logic [dataWidth-1:0] preloadData;
	logic timerLoad;
	logic countEn;
	logic busy;
	logic done;
	logic expired;
	logic [numCounters*dataWidth-1:0] counts; // Counter k at slice k
	logic [numCounters-1:0] saturated;

	AxiLiteRegs regs (.*); // Names match one to one

	SampleFsm fsm (
		.clk,
		.rstN,
		.startReq,
		.ackDone,
		.expired,
		.timerLoad,
		.countEn,
		.busy,
		.done
	);

	WindowTimer timer (
		.clk,
		.rstN,
		.load(timerLoad),
		.windowLen,
		.expired
	);

	for (genvar k = 0; k < numCounters; k++) begin : counter
		EventCounter eventCounter (
			.clk,
			.rstN,
			.eventLine(events[k]),
			.countEn,
			.clear(clearReq),
			.preloadEn(preloadEn[k]),
			.preloadData,
			.count(counts[k*dataWidth +: dataWidth]),
			.saturated(saturated[k])
		);
	end

endmodule

// ==== hw/PrefixAnd.sv ====
`timescale 1ns/100ps

module PrefixAnd #(
	parameter int width = 8, // Word width
	parameter int speed = 2 // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] PI, // Propagate bits
	output logic [width-1:0] PO // PO[i] is AND of PI[i:0]
);

	if (speed == 2) begin : sklansky
		// Row l holds spans of up to 2**l bits
		logic [width-1:0] pt [0:$clog2(width)];

		assign pt[0] = PI;
		for (genvar l = 1; l <= $clog2(width); l++) begin : lvl
			for (genvar i = 0; i < width; i++) begin : col
				if ((i >> (l - 1)) % 2 == 1) begin : merge // Upper half of its block
					assign pt[l][i] = pt[l-1][i] & pt[l-1][((i >> l) << l) + 2**(l-1) - 1];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign PO = pt[$clog2(width)]; // Log depth, high fanout

	end else if (speed == 1) begin : brentKung
		logic [width-1:0] pt [0:2*$clog2(width)-1];

		assign pt[0] = PI;
		// Up-sweep builds spans ending at block tops
		for (genvar l = 1; l <= $clog2(width); l++) begin : up
			for (genvar i = 0; i < width; i++) begin : col
				if ((i + 1) % 2**l == 0) begin : merge
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		// Down-sweep fills in between finished tops
		for (genvar s = $clog2(width) - 1; s >= 1; s--) begin : down
			for (genvar i = 0; i < width; i++) begin : col
				if (i >= 2**s && (i + 1) % 2**s == 2**(s-1)) begin : merge
					assign pt[2*$clog2(width)-s][i] =
						pt[2*$clog2(width)-s-1][i] & pt[2*$clog2(width)-s-1][i - 2**(s-1)];
				end else begin : pass
					assign pt[2*$clog2(width)-s][i] = pt[2*$clog2(width)-s-1][i];
				end
			end
		end
		assign PO = pt[2*$clog2(width)-1]; // Fewer gates, deeper

	end else if (speed == 0) begin : serial
		logic [width-1:0] pt; // Ripple chain

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : col
			assign pt[i] = pt[i-1] & PI[i];
		end
		assign PO = pt;

	end else begin : badSpeed
		$fatal(1, "PrefixAnd speed must be 0, 1 or 2");
	end

endmodule

// ==== hw/SampleFsm.sv ====
`timescale 1ns/100ps

module SampleFsm (
	input  logic clk,
	input  logic rstN,
	input  logic startReq,
	input  logic ackDone,
	input  logic expired,
	output logic timerLoad,
	output logic countEn,
	output logic busy,
	output logic done
);
	import PerfMonPkg::*;

	fsmStateT state;
	fsmStateT stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			stateIdle: begin
				if (startReq) stateNext = stateCounting;
			end
			stateCounting: begin
				if (expired) stateNext = stateDone; // Start ignored here
			end
			stateDone: begin
				if (ackDone) stateNext = stateIdle;
			end
			default: begin
				stateNext = stateIdle;
			end
		endcase
	end

	// Timer loads on the same edge that enters counting
	assign timerLoad = (state == stateIdle) && startReq;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stateIdle;
			countEn <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= stateNext;
			countEn <= stateNext == stateCounting; // Exactly windowLen cycles
			busy <= stateNext == stateCounting;
			done <= stateNext == stateDone; // Held until ackDone
		end
	end

	// Timer only runs out inside a window
	expiryInWindow: assert property (@(posedge clk) disable iff (!rstN)
		expired |-> state == stateCounting);

endmodule

// ==== hw/WindowTimer.sv ====
`timescale 1ns/100ps

module WindowTimer (
	input  logic clk,
	input  logic rstN,
	input  logic load, // Start a new window
	input  logic [PerfMonPkg::timerWidth-1:0] windowLen,
	output logic expired // Last cycle of the window
);
	import PerfMonPkg::*;

	logic [timerWidth-1:0] remain; // Cycles left, current one included
	logic [timerWidth-1:0] zeroRun; // Bits 0..i all zero
	logic [timerWidth-1:0] borrow; // Minus-one flip mask
	logic running;

	// Serial form is plenty at this width
	PrefixAnd #(.width(timerWidth), .speed(0)) borrowChain (.PI(~remain), .PO(zeroRun));

	assign borrow = {zeroRun[timerWidth-2:0], 1'b1}; // Bit i flips when lower bits are zero
	assign expired = running && remain == timerWidth'(1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			running <= 1'b0;
		end else if (load) begin
			running <= 1'b1;
		end else if (expired) begin
			running <= 1'b0; // Stop at one
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			remain <= (windowLen == '0) ? timerWidth'(1) : windowLen; // Zero means one
		end else if (running) begin
			remain <= remain ^ borrow;
		end
	end

	// Load only comes from idle, so a window never restarts on its last cycle
	singleExpiry: assert property (@(posedge clk) disable iff (!rstN)
		expired |=> !expired);

endmodule

// ==== test/PerfMonTb.sv ====
`timescale 1ns/100ps

module PerfMonTb;
	import PerfMonPkg::*;

	localparam int clkPeriod = 8; // ns
	localparam int resetCycles = 16;
	localparam int maxRecords = 16;
	localparam int perTestCycles = 400; // Bus traffic allowance per test
	localparam string goldenPath = "test/perfMonGolden.txt";

	logic clk;
	logic rstN;
	logic [addrWidth-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [dataWidth-1:0] wData;
	logic [dataWidth/8-1:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [addrWidth-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [dataWidth-1:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;
	logic [numCounters-1:0] events;

	int seed = 32'h589f; // Ready delays
	int errorCount = 0;
	int checkCount = 0;
	int numRecords = 0;
	bit loaded = 1'b0; // Golden table in memory

	// One entry per golden line
	string names [0:maxRecords-1];
	logic [timerWidth-1:0] lens [0:maxRecords-1];
	logic [numCounters-1:0] masks [0:maxRecords-1];
	logic [dataWidth-1:0] preloads [0:maxRecords-1][0:numCounters-1];
	logic [dataWidth-1:0] expCounts [0:maxRecords-1][0:numCounters-1];
	logic [numCounters-1:0] expSat [0:maxRecords-1];

	PerfMonTop DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic expectEqual(input string name, input logic [dataWidth-1:0] expected,
			input logic [dataWidth-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Entered and left on a rising edge
	task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data,
			output logic [1:0] resp);
		int delay;
		awAddr <= addr;
		wData <= data;
		wStrb <= '1; // Full words only
		awValid <= 1'b1;
		wValid <= 1'b1;
		do @(posedge clk); while (!(awReady && wReady));
		awValid <= 1'b0;
		wValid <= 1'b0;
		delay = $random(seed) & 3;
		repeat (delay) @(posedge clk); // Back-pressure on B
		bReady <= 1'b1;
		do @(posedge clk); while (!bValid);
		resp = bResp;
		bReady <= 1'b0;
	endtask

	task automatic readReg(input logic [addrWidth-1:0] addr, output logic [dataWidth-1:0] data,
			output logic [1:0] resp);
		int delay;
		arAddr <= addr;
		arValid <= 1'b1;
		do @(posedge clk); while (!arReady);
		arValid <= 1'b0;
		delay = $random(seed) & 3;
		repeat (delay) @(posedge clk); // Back-pressure on R
		rReady <= 1'b1;
		do @(posedge clk); while (!rValid);
		data = rData;
		resp = rResp;
		rReady <= 1'b0;
	endtask

	task automatic loadGolden();
		int fd;
		int fields;
		string line;
		fd = $fopen(goldenPath, "r");
		if (fd == 0) begin
			$display("could not open the golden vector file %s", goldenPath);
			errorCount++;
		end else begin
			while ($fgets(line, fd) && numRecords < maxRecords) begin
				if (line.len() < 2 || line[0] == "#") continue; // Blank or column notes
				fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
					names[numRecords], lens[numRecords], masks[numRecords],
					preloads[numRecords][0], preloads[numRecords][1],
					preloads[numRecords][2], preloads[numRecords][3],
					expCounts[numRecords][0], expCounts[numRecords][1],
					expCounts[numRecords][2], expCounts[numRecords][3], expSat[numRecords]);
				if (fields == 12) numRecords++;
				else begin
					$display("golden line has %0d fields instead of 12: %s", fields, line);
					errorCount++;
				end
			end
			$fclose(fd);
			if (numRecords == 0) begin
				$display("the golden vector file holds no test records");
				errorCount++;
			end
		end
		loaded = 1'b1;
	endtask

	// Limit grows with the windows in the table
	initial begin : watchdog
		longint limitCycles;
		wait (loaded);
		limitCycles = resetCycles + perTestCycles * (numRecords + 2);
		for (int r = 0; r < numRecords; r++) limitCycles += (lens[r] == '0) ? 1 : lens[r];
		#(limitCycles * clkPeriod);
		$display("timeout after %0d cycles, the DUT stopped answering", limitCycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		logic [1:0] resp;
		logic [dataWidth-1:0] data;
		logic [dataWidth:0] sum; // One spare bit shows a pass over all ones
		logic [dataWidth-1:0] ruleCount;
		logic [numCounters-1:0] ruleSat;
		string name;
		rstN <= 1'b0;
		awAddr <= '0;
		awValid <= 1'b0;
		wData <= '0;
		wStrb <= '0;
		wValid <= 1'b0;
		bReady <= 1'b0;
		arAddr <= '0;
		arValid <= 1'b0;
		rReady <= 1'b0;
		events <= '0;
		loadGolden();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);

		// Window register round trip, then unmapped space
		writeReg(windowAddr, 32'h1234, resp);
		expectEqual("window write resp", axiRespOkay, resp);
		readReg(windowAddr, data, resp);
		expectEqual("window readback", 32'h1234, data);
		expectEqual("window read resp", axiRespOkay, resp);
		readReg(8'h40, data, resp);
		expectEqual("unmapped read resp", axiRespSlvErr, resp);
		expectEqual("unmapped read data", 0, data);
		writeReg(8'h40, 32'hdead, resp);
		expectEqual("unmapped write resp", axiRespSlvErr, resp);

		for (int r = 0; r < numRecords; r++) begin
			name = names[r];
			writeReg(windowAddr, dataWidth'(lens[r]), resp);
			expectEqual({name, " window resp"}, axiRespOkay, resp);
			for (int k = 0; k < numCounters; k++) begin
				writeReg(counterBase + addrWidth'(4 * k), preloads[r][k], resp);
				expectEqual({name, " preload resp"}, axiRespOkay, resp);
			end
			events <= masks[r]; // Held through the window
			writeReg(ctrlAddr, 32'h1, resp); // Start
			writeReg(ctrlAddr, 32'h1, resp); // Lands in counting or done
			do begin
				readReg(ctrlAddr, data, resp);
				if (!data[1]) expectEqual({name, " busy while running"}, 1, data[0]);
			end while (!data[1]);
			events <= '0;
			expectEqual({name, " status at done"}, dataWidth'({expSat[r], 2'b10}), data);

			ruleSat = '0;
			for (int k = 0; k < numCounters; k++) begin
				sum = {1'b0, preloads[r][k]}
					+ (masks[r][k] ? ((lens[r] == '0) ? 1 : lens[r]) : 0);
				ruleCount = sum[dataWidth] ? '1 : sum[dataWidth-1:0]; // Capped
				ruleSat[k] = sum[dataWidth]; // Saw an event while at all ones
				expectEqual($sformatf("%s golden count%0d", name, k), ruleCount, expCounts[r][k]);
				readReg(counterBase + addrWidth'(4 * k), data, resp);
				expectEqual($sformatf("%s count%0d", name, k), expCounts[r][k], data);
			end
			expectEqual({name, " golden saturation"}, ruleSat, expSat[r]);

			writeReg(ctrlAddr, 32'h2, resp); // Clear in done
			for (int k = 0; k < numCounters; k++) begin
				readReg(counterBase + addrWidth'(4 * k), data, resp);
				expectEqual($sformatf("%s cleared count%0d", name, k), 0, data);
			end
			readReg(ctrlAddr, data, resp);
			expectEqual({name, " status after clear"}, 32'h2, data); // Only done left
			writeReg(ctrlAddr, 32'h4, resp); // ackDone
			readReg(ctrlAddr, data, resp);
			expectEqual({name, " status after ack"}, 32'h0, data);
		end

		$display("%0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== test/perfMonGolden.txt ====
# name windowLen eventMask preload0 preload1 preload2 preload3 count0 count1 count2 count3 satMask
# All numbers hex, a window length of zero runs one cycle
basic 000a f 00000000 00000000 00000000 00000000 0000000a 0000000a 0000000a 0000000a 0
mixed 0020 5 00000100 00000200 00000300 00000400 00000120 00000200 00000320 00000400 0
zeroLen 0000 a 00000005 00000006 00000007 00000008 00000005 00000007 00000007 00000009 0
oneLen 0001 1 0000ffff 00000000 00000000 00000000 00010000 00000000 00000000 00000000 0
saturate 0014 3 fffffff0 fffffff0 fffffff0 12345678 ffffffff ffffffff fffffff0 12345678 3
exactTop 000f 4 00000000 00000000 fffffff0 00000000 00000000 00000000 ffffffff 00000000 0
heldOnes 0003 8 00000000 00000000 00000000 ffffffff 00000000 00000000 00000000 ffffffff 8
pastTop 0002 1 fffffffe 00000000 00000000 00000000 ffffffff 00000000 00000000 00000000 1
topOnce 0001 f fffffffe fffffffe fffffffe fffffffe ffffffff ffffffff ffffffff ffffffff 0
long 012c f 00001000 00002000 abcd0000 00000000 0000112c 0000212c abcd012c 0000012c 0
quiet 0040 0 00000001 00000002 00000003 00000004 00000001 00000002 00000003 00000004 0
